//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= ita_ctrl_tb
FILELIST  ?= list.f
OBJDIR    ?= obj_dir
SIM_BIN   ?= sim_$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJDIR) -o $(SIM_BIN)
	./$(OBJDIR)/$(SIM_BIN)

clean:
	rm -rf $(OBJDIR)

//--- hdl/ita_ctrl_top.sv
/*
  ITA matrix engine controller with the tile sequencer and flow control side by
  side and edge padding on the accepted beats
*/
`timescale 1ns/1ps
`include "ita_params.svh"

module ita_ctrl_top
  import ita_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       start_i,
  input  layer_e     layer_i,
  input  dim_t       seq_length_i,
  input  dim_t       proj_space_i,
  input  dim_t       ff_size_i,
  input  dim_t       embed_size_i,
  input  logic       inp_valid_i,
  output logic       inp_ready_o,
  input  logic       weight_valid_i,
  output logic       weight_ready_o,
  input  logic       bias_valid_i,
  output logic       bias_ready_o,
  input  logic       oup_valid_i,
  input  logic       oup_ready_i,
  output logic       calc_en_o,
  output step_e      step_o,
  output counter_t   tile_x_o,
  output counter_t   tile_y_o,
  output counter_t   inner_tile_o,
  output logic       first_inner_tile_o,
  output logic       last_inner_tile_o,
  input  bias_t      inp_bias_i,
  input  logic       requant_add_i,
  output bias_t      inp_bias_pad_o,
  output lane_mask_t requant_add_o
);

  counter_t beat;
  logic     active;

  assign active = (step_o != Idle);

  ita_tile_seq u_tile_seq (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .start_i            (start_i),
    .layer_i            (layer_i),
    .seq_length_i       (seq_length_i),
    .proj_space_i       (proj_space_i),
    .ff_size_i          (ff_size_i),
    .embed_size_i       (embed_size_i),
    .calc_en_i          (calc_en_o),
    .step_o             (step_o),
    .beat_o             (beat),
    .inner_tile_o       (inner_tile_o),
    .tile_x_o           (tile_x_o),
    .tile_y_o           (tile_y_o),
    .first_inner_tile_o (first_inner_tile_o),
    .last_inner_tile_o  (last_inner_tile_o)
  );

  ita_flow_ctrl u_flow_ctrl (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .active_i          (active),
    .last_inner_tile_i (last_inner_tile_o),
    .inp_valid_i       (inp_valid_i),
    .weight_valid_i    (weight_valid_i),
    .bias_valid_i      (bias_valid_i),
    .oup_valid_i       (oup_valid_i),
    .oup_ready_i       (oup_ready_i),
    .inp_ready_o       (inp_ready_o),
    .weight_ready_o    (weight_ready_o),
    .bias_ready_o      (bias_ready_o),
    .calc_en_o         (calc_en_o)
  );

  // sees the position before the sequencer advances
  ita_edge_pad u_edge_pad (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .calc_en_i      (calc_en_o),
    .step_i         (step_o),
    .beat_i         (beat),
    .tile_x_i       (tile_x_o),
    .tile_y_i       (tile_y_o),
    .seq_length_i   (seq_length_i),
    .proj_space_i   (proj_space_i),
    .ff_size_i      (ff_size_i),
    .embed_size_i   (embed_size_i),
    .inp_bias_i     (inp_bias_i),
    .requant_add_i  (requant_add_i),
    .inp_bias_pad_o (inp_bias_pad_o),
    .requant_add_o  (requant_add_o)
  );

endmodule

//--- hdl/ita_edge_pad.sv
/*
  ITA edge padder that zeroes bias and requant-add lanes past the matrix edge
  and registers them on each accepted beat
*/
`timescale 1ns/1ps
`include "ita_params.svh"

module ita_edge_pad
  import ita_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       calc_en_i,
  input  step_e      step_i,
  input  counter_t   beat_i,
  input  counter_t   tile_x_i,
  input  counter_t   tile_y_i,
  input  dim_t       seq_length_i,
  input  dim_t       proj_space_i,
  input  dim_t       ff_size_i,
  input  dim_t       embed_size_i,
  input  bias_t      inp_bias_i,
  input  logic       requant_add_i,
  output bias_t      inp_bias_pad_o,
  output lane_mask_t requant_add_o
);

  localparam int LogM = $clog2(`ITA_M);
  localparam int PosW = `ITA_CNT_W + LogM;

  typedef logic [PosW-1:0] pos_t;

  pos_t       row_pos, col_base;
  dim_t       col_dim;
  lane_mask_t keep;
  bias_t      bias_pad;
  bias_t      bias_q;
  lane_mask_t requant_q;

  always_comb begin
    case (step_i)
      F1:      col_dim = ff_size_i;
      F2:      col_dim = embed_size_i;
      default: col_dim = proj_space_i;
    endcase
  end

  // beat walks down the rows first, then steps N columns
  assign row_pos  = pos_t'(tile_y_i) * pos_t'(`ITA_M) + pos_t'(beat_i % `ITA_M);
  assign col_base = pos_t'(tile_x_i) * pos_t'(`ITA_M)
                  + pos_t'(beat_i / `ITA_M) * pos_t'(`ITA_N);

  always_comb begin
    for (int i = 0; i < `ITA_N; i++) begin
      keep[i] = (row_pos < pos_t'(seq_length_i))
             && (col_base + pos_t'(i) < pos_t'(col_dim));
      bias_pad[i] = keep[i] ? inp_bias_i[i] : '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bias_q    <= '{default: '0};
      requant_q <= '0;
    end else if (calc_en_i) begin
      bias_q    <= bias_pad;
      requant_q <= keep & {`ITA_N{requant_add_i}};  // one flag for all lanes
    end
  end

  assign inp_bias_pad_o = bias_q;
  assign requant_add_o  = requant_q;

  // column dimension is only meaningful inside a step
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    calc_en_i |-> step_i != Idle)
    else $error("padding beat outside a step");

endmodule

//--- hdl/ita_flow_ctrl.sv
/*
  ITA flow control that counts output beats still waiting to drain and gates
  the input, weight and bias handshakes
*/
`timescale 1ns/1ps
`include "ita_params.svh"

module ita_flow_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic active_i,
  input  logic last_inner_tile_i,
  input  logic inp_valid_i,
  input  logic weight_valid_i,
  input  logic bias_valid_i,
  input  logic oup_valid_i,
  input  logic oup_ready_i,
  output logic inp_ready_o,
  output logic weight_ready_o,
  output logic bias_ready_o,
  output logic calc_en_o
);

  localparam int CntW = $clog2(`ITA_FIFO_DEPTH + 1);

  logic [CntW-1:0] ongoing_d, ongoing_q;
  logic            stall, open, push, pop;

  assign stall = (ongoing_q >= CntW'(`ITA_FIFO_DEPTH));
  assign open  = active_i && !stall;

  // each ready waits on the other two operands
  assign inp_ready_o    = open && weight_valid_i && bias_valid_i;
  assign weight_ready_o = open && inp_valid_i && bias_valid_i;
  assign bias_ready_o   = open && inp_valid_i && weight_valid_i;
  assign calc_en_o      = open && inp_valid_i && weight_valid_i && bias_valid_i;

  assign push = calc_en_o && last_inner_tile_i;  // beat produces output
  assign pop  = oup_valid_i && oup_ready_i;

  always_comb begin
    ongoing_d = ongoing_q;
    if (push && !pop) begin
      ongoing_d = ongoing_q + 1'b1;
    end else if (pop && !push) begin
      ongoing_d = ongoing_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ongoing_q <= '0;
    end else begin
      ongoing_q <= ongoing_d;
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    ongoing_q <= CntW'(`ITA_FIFO_DEPTH))
    else $error("outstanding output count above FIFO depth");

  // downstream must not drain what was never produced
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (pop && !push) |-> ongoing_q != '0)
    else $error("output drained with nothing outstanding");

endmodule

//--- hdl/ita_params.svh
/*
  ITA matrix engine sizing for tile geometry, datapath widths and output FIFO depth
*/
`ifndef ITA_PARAMS_SVH
`define ITA_PARAMS_SVH

// tile edge in elements
`define ITA_M 16

// lanes per beat as a power of two dividing ITA_M
`define ITA_N 4

// beats needed to cover one M x M tile
`define ITA_BEATS ((`ITA_M * `ITA_M) / `ITA_N)

// matrix dimension in elements
`define ITA_DIM_W 12

// beat and tile counters
`define ITA_CNT_W 10

// one bias lane
`define ITA_BIAS_W 24

// output beats allowed in flight before the operand side stalls
`define ITA_FIFO_DEPTH 2

`endif

//--- hdl/ita_pkg.sv
/*
  ITA controller types for step and layer encodings, counters and lane vectors
*/
`include "ita_params.svh"

package ita_pkg;

  // current step of the sequencer
  typedef enum logic [1:0] {
    Idle,
    MatMul,  // linear layer
    F1,      // first feedforward projection
    F2       // second feedforward projection
  } step_e;

  typedef enum logic {
    Linear,
    Feedforward
  } layer_e;

  typedef logic [`ITA_CNT_W-1:0] counter_t;

  typedef logic [`ITA_DIM_W-1:0] dim_t;

  // one bias word per lane
  typedef logic [`ITA_BIAS_W-1:0] bias_t [`ITA_N];

  typedef logic [`ITA_N-1:0] lane_mask_t;

endpackage

//--- hdl/ita_tile_seq.sv
/*
  ITA tile sequencer that walks beats, inner tiles and output tiles of a Linear
  or Feedforward layer and steps MatMul or F1 then F2
*/
`timescale 1ns/1ps
`include "ita_params.svh"

module ita_tile_seq
  import ita_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     start_i,
  input  layer_e   layer_i,
  input  dim_t     seq_length_i,
  input  dim_t     proj_space_i,
  input  dim_t     ff_size_i,
  input  dim_t     embed_size_i,
  input  logic     calc_en_i,
  output step_e    step_o,
  output counter_t beat_o,
  output counter_t inner_tile_o,
  output counter_t tile_x_o,
  output counter_t tile_y_o,
  output logic     first_inner_tile_o,
  output logic     last_inner_tile_o
);

  localparam counter_t LastBeat = counter_t'(`ITA_BEATS - 1);

  step_e    step_d, step_q;
  counter_t beat_d, beat_q;
  counter_t inner_d, inner_q;
  counter_t tile_x_d, tile_x_q;
  counter_t tile_y_d, tile_y_q;
  counter_t n_row, n_col, n_inner;  // tile counts of the current step
  logic     beat_last, inner_last, x_last, y_last;

  // dimension rounded up to whole tiles
  function automatic counter_t num_tiles(input dim_t dim);
    logic [`ITA_DIM_W:0] padded;
    padded = {1'b0, dim} + (`ITA_DIM_W + 1)'(`ITA_M - 1);
    return counter_t'(padded / (`ITA_DIM_W + 1)'(`ITA_M));
  endfunction

  always_comb begin
    n_row = num_tiles(seq_length_i);  // rows are the sequence in every step
    case (step_q)
      F1: begin
        n_col   = num_tiles(ff_size_i);
        n_inner = num_tiles(embed_size_i);
      end
      F2: begin
        n_col   = num_tiles(embed_size_i);
        n_inner = num_tiles(ff_size_i);
      end
      default: begin
        n_col   = num_tiles(proj_space_i);
        n_inner = num_tiles(embed_size_i);
      end
    endcase
  end

  assign beat_last  = (beat_q == LastBeat);
  assign inner_last = (inner_q == n_inner - 1'b1);
  assign x_last     = (tile_x_q == n_col - 1'b1);
  assign y_last     = (tile_y_q == n_row - 1'b1);

  // beat innermost, then inner tile, tile_x, tile_y
  always_comb begin
    step_d   = step_q;
    beat_d   = beat_q;
    inner_d  = inner_q;
    tile_x_d = tile_x_q;
    tile_y_d = tile_y_q;

    if (step_q == Idle) begin
      if (start_i) begin
        step_d = (layer_i == Feedforward) ? F1 : MatMul;
      end
    end else if (calc_en_i) begin
      beat_d = beat_q + 1'b1;
      if (beat_last) begin
        beat_d  = '0;
        inner_d = inner_q + 1'b1;
        if (inner_last) begin  // output tile complete
          inner_d  = '0;
          tile_x_d = tile_x_q + 1'b1;
          if (x_last) begin
            tile_x_d = '0;
            tile_y_d = tile_y_q + 1'b1;
            if (y_last) begin  // end of step
              tile_y_d = '0;
              step_d   = (step_q == F1) ? F2 : Idle;
            end
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      step_q   <= Idle;
      beat_q   <= '0;
      inner_q  <= '0;
      tile_x_q <= '0;
      tile_y_q <= '0;
    end else begin
      step_q   <= step_d;
      beat_q   <= beat_d;
      inner_q  <= inner_d;
      tile_x_q <= tile_x_d;
      tile_y_q <= tile_y_d;
    end
  end

  assign step_o       = step_q;
  assign beat_o       = beat_q;
  assign inner_tile_o = inner_q;
  assign tile_x_o     = tile_x_q;
  assign tile_y_o     = tile_y_q;

  assign first_inner_tile_o = (step_q != Idle) && (inner_q == '0);
  assign last_inner_tile_o  = (step_q != Idle) && inner_last;

  // the flow controller only strobes beats while a step runs
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    calc_en_i |-> step_q != Idle)
    else $error("beat strobe while sequencer is idle");

endmodule

//--- list.f
+incdir+hdl
+incdir+tb
hdl/ita_pkg.sv
hdl/ita_tile_seq.sv
hdl/ita_flow_ctrl.sv
hdl/ita_edge_pad.sv
hdl/ita_ctrl_top.sv
tb/ita_ctrl_tb.sv

//--- tb/ita_ctrl_ref.svh
/*
  ITA controller reference model with tile counts, lane padding, LFSR and typed compares
*/
`ifndef ITA_CTRL_REF_SVH
`define ITA_CTRL_REF_SVH

// whole tiles needed to cover a dimension
function automatic int tiles_for(input int dim);
  return (dim + `ITA_M - 1) / `ITA_M;
endfunction

function automatic int col_dim_of(input step_e st, input int proj, input int ff, input int embed);
  if (st == F1) return ff;
  if (st == F2) return embed;
  return proj;
endfunction

function automatic int inner_dim_of(input step_e st, input int ff, input int embed);
  return (st == F2) ? ff : embed;
endfunction

// lanes of a beat that fall inside the matrix
function automatic lane_mask_t lane_keep(input int beat, input int tx, input int ty,
                                         input int rows, input int cols);
  lane_mask_t keep;
  int         row;
  int         col;
  row = ty * `ITA_M + (beat % `ITA_M);
  for (int i = 0; i < `ITA_N; i++) begin
    col     = tx * `ITA_M + (beat / `ITA_M) * `ITA_N + i;
    keep[i] = (row < rows) && (col < cols);
  end
  return keep;
endfunction

// x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
  return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

task automatic check_step(input string name, input step_e exp, input step_e act);
  if (exp !== act) begin
    $display("Fail %s: expected %s, actual %s", name, exp.name(), act.name());
    stop_run();
  end
endtask

task automatic check_count(input string name, input counter_t exp, input counter_t act);
  if (exp !== act) begin
    $display("Fail %s: expected %0d, actual %0d", name, exp, act);
    stop_run();
  end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
  if (exp !== act) begin
    $display("Fail %s: expected %b, actual %b", name, exp, act);
    stop_run();
  end
endtask

task automatic check_bias(input string name, input bias_t exp, input bias_t act);
  for (int i = 0; i < `ITA_N; i++) begin
    if (exp[i] !== act[i]) begin
      $display("Fail %s lane %0d: expected %h, actual %h", name, i, exp[i], act[i]);
      stop_run();
    end
  end
endtask

task automatic check_mask(input string name, input lane_mask_t exp, input lane_mask_t act);
  if (exp !== act) begin
    $display("Fail %s: expected %b, actual %b", name, exp, act);
    stop_run();
  end
endtask

`endif

//--- tb/ita_ctrl_tb.sv
/*
  ITA controller testbench with random operand valids, a reference scoreboard
  and directed layer runs
*/
`timescale 1ns/1ps
`include "ita_params.svh"

module ita_ctrl_tb
  import ita_pkg::*;
();

  localparam int WaitLimit = 200000;

  logic clk_i = 1'b0;
  logic rst_ni = 1'b0;
  logic start_i = 1'b0;
  layer_e layer_i = Linear;
  dim_t seq_length_i = '0;
  dim_t proj_space_i = '0;
  dim_t ff_size_i = '0;
  dim_t embed_size_i = '0;
  logic inp_valid_i = 1'b0;
  logic weight_valid_i = 1'b0;
  logic bias_valid_i = 1'b0;
  logic oup_valid_i = 1'b0;
  logic oup_ready_i = 1'b0;
  bias_t inp_bias_i = '{default: '0};
  logic requant_add_i = 1'b0;
  logic inp_ready_o, weight_ready_o, bias_ready_o, calc_en_o;
  step_e step_o;
  counter_t tile_x_o, tile_y_o, inner_tile_o;
  logic first_inner_tile_o, last_inner_tile_o;
  bias_t inp_bias_pad_o;
  lane_mask_t requant_add_o;

  // reference state
  logic [15:0] lfsr = 16'd43;
  step_e m_step = Idle;
  int m_beat, m_inner, m_x, m_y, outstanding;
  int beats_mm, beats_f1, beats_f2;
  logic drain_en = 1'b1;
  logic have_pad = 1'b0;
  bias_t exp_bias;
  lane_mask_t exp_req;

  ita_ctrl_top dut0 (.*);

  always #4 clk_i = ~clk_i;

  task automatic stop_run();
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped at first error");
  endtask

  `include "ita_ctrl_ref.svh"

  function automatic logic draw_bit();
    logic b;
    b = lfsr[15];
    lfsr = lfsr_next(lfsr);
    return b;
  endfunction

  // scoreboard that also drives the random operands and drains
  always @(posedge clk_i) begin
    logic open, cal;
    int rows, cols, n_x, n_y, n_in;
    bias_t nb;
    if (rst_ni) begin
      open = (m_step != Idle) && (outstanding < `ITA_FIFO_DEPTH);
      cal  = open && inp_valid_i && weight_valid_i && bias_valid_i;
      check_bit("calc_en", cal, calc_en_o);
      check_bit("inp_ready", open && weight_valid_i && bias_valid_i, inp_ready_o);
      check_bit("weight_ready", open && inp_valid_i && bias_valid_i, weight_ready_o);
      check_bit("bias_ready", open && inp_valid_i && weight_valid_i, bias_ready_o);
      check_step("step", m_step, step_o);
      if (have_pad) begin
        check_bias("bias_pad", exp_bias, inp_bias_pad_o);
        check_mask("requant_pad", exp_req, requant_add_o);
      end
      if (calc_en_o && step_o == MatMul) beats_mm++;
      if (calc_en_o && step_o == F1) beats_f1++;
      if (calc_en_o && step_o == F2) beats_f2++;
      rows = seq_length_i;
      cols = col_dim_of(m_step, proj_space_i, ff_size_i, embed_size_i);
      n_y  = tiles_for(rows);
      n_x  = tiles_for(cols);
      n_in = tiles_for(inner_dim_of(m_step, ff_size_i, embed_size_i));
      check_bit("first_inner", (m_step != Idle) && (m_inner == 0), first_inner_tile_o);
      check_bit("last_inner", (m_step != Idle) && (m_inner == n_in - 1), last_inner_tile_o);
      if (m_step != Idle) begin
        check_count("tile_x", counter_t'(m_x), tile_x_o);
        check_count("tile_y", counter_t'(m_y), tile_y_o);
        check_count("inner_tile", counter_t'(m_inner), inner_tile_o);
      end
      if (cal) begin
        exp_req = lane_keep(m_beat, m_x, m_y, rows, cols);
        for (int i = 0; i < `ITA_N; i++) exp_bias[i] = exp_req[i] ? inp_bias_i[i] : '0;
        exp_req  = exp_req & {`ITA_N{requant_add_i}};
        have_pad = 1'b1;
        if (m_inner == n_in - 1) outstanding++;  // output beat produced
        m_beat++;
        if (m_beat == `ITA_BEATS) begin
          m_beat = 0;
          m_inner++;
          if (m_inner == n_in) begin
            m_inner = 0;
            m_x++;
            if (m_x == n_x) begin
              m_x = 0;
              m_y++;
              if (m_y == n_y) begin
                m_y = 0;
                m_step = (m_step == F1) ? F2 : Idle;
              end
            end
          end
        end
      end
      if (oup_valid_i && oup_ready_i) outstanding--;
      if (m_step == Idle && start_i) m_step = (layer_i == Feedforward) ? F1 : MatMul;
      for (int i = 0; i < `ITA_N; i++) begin
        for (int b = 0; b < `ITA_BIAS_W; b++) nb[i][b] = draw_bit();
      end
      inp_bias_i     <= nb;
      requant_add_i  <= draw_bit();
      inp_valid_i    <= draw_bit() | draw_bit();
      weight_valid_i <= draw_bit() | draw_bit();
      bias_valid_i   <= draw_bit() | draw_bit();
      oup_valid_i    <= drain_en && (outstanding > 0) && draw_bit();
      oup_ready_i    <= 1'b1;
    end
  end

  task automatic wait_step_idle(input string name);
    int n;
    n = 0;
    while (step_o != Idle) begin
      @(negedge clk_i);
      n++;
      if (n > WaitLimit) begin
        $display("timeout: %s never returned to idle", name);
        stop_run();
      end
    end
  endtask

  task automatic wait_outstanding(input int target);
    int n;
    n = 0;
    while (outstanding != target) begin
      @(negedge clk_i);
      n++;
      if (n > WaitLimit) begin
        $display("timeout: outstanding tiles never reached %0d", target);
        stop_run();
      end
    end
  endtask

  task automatic launch(input layer_e ly, input int seq, input int proj, input int ff,
                        input int embed);
    @(posedge clk_i);
    layer_i      <= ly;
    seq_length_i <= dim_t'(seq);
    proj_space_i <= dim_t'(proj);
    ff_size_i    <= dim_t'(ff);
    embed_size_i <= dim_t'(embed);
    start_i      <= 1'b1;
    @(posedge clk_i);
    start_i <= 1'b0;
    @(negedge clk_i);
  endtask

  task automatic run_linear(input string name, input int seq, input int proj, input int embed);
    int b0;
    b0 = beats_mm;
    launch(Linear, seq, proj, 0, embed);
    wait_step_idle(name);
    check_count(name, counter_t'(tiles_for(seq) * tiles_for(proj) * tiles_for(embed)
                * `ITA_BEATS), counter_t'(beats_mm - b0));
  endtask

  task automatic run_ff(input string name, input int seq, input int ff, input int embed);
    int b1, b2;
    b1 = beats_f1;
    b2 = beats_f2;
    launch(Feedforward, seq, 0, ff, embed);
    wait_step_idle(name);
    check_count({name, " F1"}, counter_t'(tiles_for(seq) * tiles_for(ff) * tiles_for(embed)
                * `ITA_BEATS), counter_t'(beats_f1 - b1));
    check_count({name, " F2"}, counter_t'(tiles_for(seq) * tiles_for(embed) * tiles_for(ff)
                * `ITA_BEATS), counter_t'(beats_f2 - b2));
  endtask

  initial begin
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_step("reset step", Idle, step_o);
    check_bit("reset calc_en", 1'b0, calc_en_o);
    check_bit("reset ready", 1'b0, inp_ready_o | weight_ready_o | bias_ready_o);
    check_bit("reset inner flags", 1'b0, first_inner_tile_o | last_inner_tile_o);
    check_bias("reset bias_pad", '{default: '0}, inp_bias_pad_o);
    check_mask("reset requant_pad", '0, requant_add_o);

    run_linear("linear length", 32, 48, 32);
    run_ff("feedforward order", 16, 32, 16);

    // hold drains until the output FIFO limit is hit
    wait_outstanding(0);
    drain_en = 1'b0;
    launch(Linear, 16, 48, 0, 16);
    wait_outstanding(`ITA_FIFO_DEPTH);
    repeat (6) begin
      @(negedge clk_i);
      check_bit("backpressure calc_en", 1'b0, calc_en_o);
      check_bit("backpressure ready", 1'b0, inp_ready_o | weight_ready_o | bias_ready_o);
    end
    drain_en = 1'b1;
    wait_step_idle("backpressure");

    run_linear("linear padding", 20, 24, 16);
    run_ff("feedforward padding", 20, 40, 32);
    wait_outstanding(0);
    repeat (4) @(negedge clk_i);
    $display("*** PASSED ***");
    $finish;
  end

endmodule
